//--- src/ppu_sprite_pkg.sv
`default_nettype none

package ppu_sprite_pkg;

	localparam int W_DATA    = 32;
	localparam int W_OUTDATA = 15;
	localparam int W_COORD   = 10;
	localparam int W_ADDR    = 16;
	localparam int W_PIX_MAX = 16;   // ARGB1555 is the widest packed pixel.

	typedef logic [W_DATA-1:0]           data_t;
	typedef logic [W_OUTDATA-1:0]        pix_t;
	typedef logic [W_COORD-1:0]          coord_t;
	typedef logic signed [W_COORD:0]     xoffs_t;   // beam x minus sprite x.
	typedef logic [W_ADDR-1:0]           addr_t;
	typedef logic [2:0]                  pixel_mode_t;

	// Codes 3 to 7 are reserved and decode as PAL4.
	localparam pixel_mode_t MODE_ARGB1555 = 3'd0;
	localparam pixel_mode_t MODE_PAL8     = 3'd1;
	localparam pixel_mode_t MODE_PAL4     = 3'd2;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_AGU,
		ST_STREAM
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- src/sprite_agu.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_agu (
	input  wire                              clk,
	input  wire                              rst_n,

	input  wire                              agu_req,
	output logic                             agu_ack,

	input  wire ppu_sprite_pkg::coord_t      beam_y,
	input  wire ppu_sprite_pkg::coord_t      cfg_sprite_x,
	input  wire ppu_sprite_pkg::coord_t      cfg_sprite_y,
	input  wire                              cfg_tilesize,
	input  wire ppu_sprite_pkg::pixel_mode_t cfg_pixel_mode,
	input  wire ppu_sprite_pkg::addr_t       cfg_base_addr,

	output logic                             agu_active,
	output ppu_sprite_pkg::xoffs_t           agu_x_start,

	input  wire                              load_ack,
	output ppu_sprite_pkg::addr_t            bus_addr
);

	import ppu_sprite_pkg::*;

	coord_t     row;
	logic       row_hit;
	logic [1:0] bpp_shift;
	logic [2:0] row_shift;
	addr_t      row_offs;
	logic       req_new;

	// a held request is answered once, the ack itself masks the second cycle.
	assign req_new = agu_req && !agu_ack;

	// rows above the sprite wrap to large values and fail the size test.
	assign row     = beam_y - cfg_sprite_y;
	assign row_hit = cfg_tilesize ? (row < coord_t'(16)) : (row < coord_t'(8));

	always_comb begin
		case (cfg_pixel_mode)
			MODE_ARGB1555: bpp_shift = 2'd2;   // 16 bits per pixel.
			MODE_PAL8:     bpp_shift = 2'd1;   // 8 bits per pixel.
			MODE_PAL4:     bpp_shift = 2'd0;   // 4 bits per pixel.
			default:       bpp_shift = 2'd0;
		endcase
	end

	// Words per row is (8 << tilesize) * (4 << bpp_shift) / 32.
	assign row_shift = {1'b0, bpp_shift} + {2'b00, cfg_tilesize};
	assign row_offs  = addr_t'(row[3:0]) << row_shift;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			agu_ack    <= 1'b0;
			agu_active <= 1'b0;
		end else begin
			agu_ack <= req_new;
			if (req_new) begin
				agu_active <= row_hit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_new) begin
			agu_x_start <= -xoffs_t'(cfg_sprite_x);   // beam x starts at zero.
			bus_addr    <= cfg_base_addr + row_offs;
		end else if (load_ack) begin
			bus_addr <= bus_addr + addr_t'(1);   // next word of the same row.
		end
	end

endmodule

`default_nettype wire

//--- src/pixel_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_streamer (
	input  wire                              clk,
	input  wire                              rst_n,

	input  wire                              stream_flush,
	input  wire ppu_sprite_pkg::pixel_mode_t pixel_mode,
	input  wire [3:0]                        palette_offs,

	output logic                             load_req,
	input  wire                              load_ack,
	input  wire ppu_sprite_pkg::data_t       load_data,

	output logic                             pix_vld,
	input  wire                              pix_rdy,
	output ppu_sprite_pkg::pix_t             pix_data,
	output logic                             pix_alpha
);

	import ppu_sprite_pkg::*;

	data_t                shifter;
	data_t                prefetch;
	logic                 shift_vld;
	logic                 pre_vld;
	logic                 running;
	logic [2:0]           pix_cnt;
	logic [2:0]           last_cnt;
	logic [4:0]           pix_width;
	logic [W_PIX_MAX-1:0] pix_raw;
	logic [7:0]           pal8_index;
	logic [3:0]           pal4_index;
	logic                 pop;
	logic                 word_done;
	logic                 shift_free;

	// pixels are taken from the bottom of the shifter, least significant first.
	assign pix_raw    = shifter[W_PIX_MAX-1:0];
	assign pal8_index = pix_raw[7:0] + {palette_offs, 4'h0};   // wraps at 256.
	assign pal4_index = pix_raw[3:0];

	always_comb begin
		case (pixel_mode)
			MODE_ARGB1555: begin
				pix_data  = pix_raw[W_OUTDATA-1:0];
				pix_alpha = pix_raw[W_OUTDATA];
				last_cnt  = 3'd1;
				pix_width = 5'd16;
			end
			MODE_PAL8: begin
				pix_data  = pix_t'(pal8_index);
				pix_alpha = |pix_raw[7:0];   // index zero is transparent.
				last_cnt  = 3'd3;
				pix_width = 5'd8;
			end
			default: begin
				pix_data  = pix_t'({palette_offs, pal4_index});
				pix_alpha = |pal4_index;
				last_cnt  = 3'd7;
				pix_width = 5'd4;
			end
		endcase
	end

	assign pix_vld    = shift_vld;
	assign pop        = shift_vld && pix_rdy;
	assign word_done  = pop && (pix_cnt == last_cnt);
	assign shift_free = !shift_vld || word_done;

	// no fetches until the first scanline has started.
	assign load_req = running && !(shift_vld && pre_vld);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running   <= 1'b0;
			shift_vld <= 1'b0;
			pre_vld   <= 1'b0;
			pix_cnt   <= 3'd0;
		end else if (stream_flush) begin
			running   <= 1'b1;
			shift_vld <= 1'b0;
			pre_vld   <= 1'b0;
			pix_cnt   <= 3'd0;
		end else if (shift_free) begin
			// The prefetch word moves down first; a new word refills behind it.
			shift_vld <= pre_vld || load_ack;
			pre_vld   <= pre_vld && load_ack;
			pix_cnt   <= 3'd0;
		end else begin
			if (pop) begin
				pix_cnt <= pix_cnt + 3'd1;
			end
			if (load_ack) begin
				pre_vld <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift_free) begin
			shifter <= pre_vld ? prefetch : load_data;
		end else if (pop) begin
			shifter <= shifter >> pix_width;
		end
		if (load_ack) begin
			prefetch <= load_data;   // only kept when pre_vld is set.
		end
	end

endmodule

`default_nettype wire

//--- src/sprite_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_ctrl (
	input  wire                         clk,
	input  wire                         rst_n,

	input  wire                         flush,
	input  wire                         en,
	input  wire                         cfg_tilesize,

	output logic                        agu_req,
	input  wire                         agu_ack,
	input  wire                         agu_active,
	input  wire ppu_sprite_pkg::xoffs_t agu_x_start,

	input  wire                         load_req,
	output logic                        load_ack,
	output logic                        stream_flush,

	input  wire                         pix_vld,
	output logic                        pix_rdy,
	input  wire                         pix_alpha,

	output logic                        bus_vld,
	input  wire                         bus_rdy,

	output logic                        out_vld,
	input  wire                         out_rdy,
	output logic                        out_alpha
);

	import ppu_sprite_pkg::*;

	ctrl_state_t state;
	xoffs_t      xoffs;
	xoffs_t      tile_w;
	logic        in_stream;
	logic        row_active;
	logic        in_sprite;
	logic        past_right;
	logic        out_beat;
	logic        bus_new;
	logic        bus_hold;
	logic        bus_dirty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else if (flush) begin
			state <= ST_WAIT_AGU;
		end else if (state == ST_WAIT_AGU && agu_ack) begin
			state <= ST_STREAM;
		end
	end

	assign in_stream  = (state == ST_STREAM);
	assign row_active = in_stream && agu_active;

	// wait for a stale beat to drain so that bus_addr holds until bus_rdy.
	assign agu_req      = en && (state == ST_WAIT_AGU) && !bus_dirty && !flush;
	assign stream_flush = flush || (state == ST_WAIT_AGU);

	assign tile_w     = cfg_tilesize ? xoffs_t'(16) : xoffs_t'(8);
	assign in_sprite  = (xoffs >= 0) && (xoffs < tile_w);
	assign past_right = (xoffs >= tile_w);
	assign out_beat   = out_vld && out_rdy;

	// The offset stops past the right edge so a long scanline cannot wrap it.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xoffs <= '0;
		end else if (agu_ack && !flush) begin
			xoffs <= agu_x_start;
		end else if (out_beat && in_stream && !past_right) begin
			xoffs <= xoffs + xoffs_t'(1);
		end
	end

	// a raised request is held until bus_rdy, whatever happens to the row.
	assign bus_new  = row_active && en && !flush && !past_right && load_req;
	assign bus_vld  = bus_hold || bus_new;
	assign load_ack = bus_vld && bus_rdy && !bus_dirty && !flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_hold  <= 1'b0;
			bus_dirty <= 1'b0;
		end else begin
			bus_hold  <= bus_vld && !bus_rdy;
			bus_dirty <= bus_vld && !bus_rdy && (bus_dirty || flush);   // beat predates flush.
		end
	end

	// outside the sprite the beam runs freely, inside it waits for pixels.
	assign out_vld   = !en || (in_stream && !flush && (!in_sprite || !agu_active || pix_vld));
	assign pix_rdy   = out_rdy && en && !flush && row_active && in_sprite;
	assign out_alpha = en && row_active && in_sprite && pix_alpha;

endmodule

`default_nettype wire

//--- src/ppu_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_sprite (
	input  wire                              clk,
	input  wire                              rst_n,

	input  wire                              flush,
	input  wire                              en,
	input  wire ppu_sprite_pkg::coord_t      beam_y,

	input  wire                              cfg_tilesize,
	input  wire ppu_sprite_pkg::pixel_mode_t cfg_pixel_mode,
	input  wire [3:0]                        cfg_palette_offs,
	input  wire ppu_sprite_pkg::coord_t      cfg_sprite_x,
	input  wire ppu_sprite_pkg::coord_t      cfg_sprite_y,
	input  wire ppu_sprite_pkg::addr_t       cfg_base_addr,

	output wire                              bus_vld,
	input  wire                              bus_rdy,
	output wire ppu_sprite_pkg::addr_t       bus_addr,
	input  wire ppu_sprite_pkg::data_t       bus_data,

	output wire                              out_vld,
	input  wire                              out_rdy,
	output wire                              out_alpha,
	output wire ppu_sprite_pkg::pix_t        out_pixdata
);

	import ppu_sprite_pkg::*;

	logic   agu_req;
	logic   agu_ack;
	logic   agu_active;
	xoffs_t agu_x_start;
	logic   load_req;
	logic   load_ack;
	logic   stream_flush;
	logic   pix_vld;
	logic   pix_rdy;
	logic   pix_alpha;

	sprite_ctrl i_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.en           (en),
		.cfg_tilesize (cfg_tilesize),
		.agu_req      (agu_req),
		.agu_ack      (agu_ack),
		.agu_active   (agu_active),
		.agu_x_start  (agu_x_start),
		.load_req     (load_req),
		.load_ack     (load_ack),
		.stream_flush (stream_flush),
		.pix_vld      (pix_vld),
		.pix_rdy      (pix_rdy),
		.pix_alpha    (pix_alpha),
		.bus_vld      (bus_vld),
		.bus_rdy      (bus_rdy),
		.out_vld      (out_vld),
		.out_rdy      (out_rdy),
		.out_alpha    (out_alpha)
	);

	sprite_agu i_agu (
		.clk            (clk),
		.rst_n          (rst_n),
		.agu_req        (agu_req),
		.agu_ack        (agu_ack),
		.beam_y         (beam_y),
		.cfg_sprite_x   (cfg_sprite_x),
		.cfg_sprite_y   (cfg_sprite_y),
		.cfg_tilesize   (cfg_tilesize),
		.cfg_pixel_mode (cfg_pixel_mode),
		.cfg_base_addr  (cfg_base_addr),
		.agu_active     (agu_active),
		.agu_x_start    (agu_x_start),
		.load_ack       (load_ack),
		.bus_addr       (bus_addr)
	);

	pixel_streamer i_streamer (
		.clk          (clk),
		.rst_n        (rst_n),
		.stream_flush (stream_flush),
		.pixel_mode   (cfg_pixel_mode),
		.palette_offs (cfg_palette_offs),
		.load_req     (load_req),
		.load_ack     (load_ack),
		.load_data    (bus_data),
		.pix_vld      (pix_vld),
		.pix_rdy      (pix_rdy),
		.pix_data     (out_pixdata),
		.pix_alpha    (pix_alpha)
	);

endmodule

`default_nettype wire

//--- tb/tb_ppu_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_sprite;

	import ppu_sprite_pkg::*;

	localparam int          N_LINES        = 200;
	localparam int          LINE_BEATS     = 64;
	localparam int          TIMEOUT_CYCLES = N_LINES * LINE_BEATS * 8 + 1000;
	localparam logic [31:0] SEED           = 32'h1136_4d9c;

	logic        clk;
	logic        rst_n;
	logic        flush;
	logic        en;
	coord_t      beam_y;
	logic        cfg_tilesize;
	pixel_mode_t cfg_pixel_mode;
	logic [3:0]  cfg_palette_offs;
	coord_t      cfg_sprite_x;
	coord_t      cfg_sprite_y;
	addr_t       cfg_base_addr;
	logic        bus_vld;
	logic        bus_rdy;
	addr_t       bus_addr;
	data_t       bus_data;
	logic        out_vld;
	logic        out_rdy;
	logic        out_alpha;
	pix_t        out_pixdata;

	data_t mem [0:65535];
	int    errors = 0;
	int    cycles = 0;
	int    beats = 0;
	int    fetches = 0;
	int    stall_cycles = 0;
	logic  stale = 1'b0;   // a beat raised before the last flush is still open.
	logic  prev_vld = 1'b0;
	logic  prev_rdy = 1'b0;
	addr_t prev_addr = '0;

	ppu_sprite i_dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.flush            (flush),
		.en               (en),
		.beam_y           (beam_y),
		.cfg_tilesize     (cfg_tilesize),
		.cfg_pixel_mode   (cfg_pixel_mode),
		.cfg_palette_offs (cfg_palette_offs),
		.cfg_sprite_x     (cfg_sprite_x),
		.cfg_sprite_y     (cfg_sprite_y),
		.cfg_base_addr    (cfg_base_addr),
		.bus_vld          (bus_vld),
		.bus_rdy          (bus_rdy),
		.bus_addr         (bus_addr),
		.bus_data         (bus_data),
		.out_vld          (out_vld),
		.out_rdy          (out_rdy),
		.out_alpha        (out_alpha),
		.out_pixdata      (out_pixdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int tile_size();
		return cfg_tilesize ? 16 : 8;
	endfunction

	function automatic int pixel_bits();
		case (cfg_pixel_mode)
			MODE_ARGB1555: return 16;
			MODE_PAL8:     return 8;
			default:       return 4;   // reserved codes decode as PAL4.
		endcase
	endfunction

	function automatic int sprite_row();
		return (int'(beam_y) - int'(cfg_sprite_y) + 1024) % 1024;
	endfunction

	function automatic logic row_hit();
		return en && (sprite_row() < tile_size());
	endfunction

	function automatic addr_t row_addr();
		return addr_t'(int'(cfg_base_addr) + sprite_row() * (tile_size() * pixel_bits() / 32));
	endfunction

	// Result is {alpha, colour}, zero where the beam misses the sprite.
	function automatic logic [15:0] expected_pixel(input int beam_x);
		int          x;
		int          bits;
		int          per_word;
		int          index;
		int          colour;
		addr_t       addr;
		logic [15:0] raw;
		x = beam_x - int'(cfg_sprite_x);
		if (!row_hit() || x < 0 || x >= tile_size()) begin
			return 16'h0000;
		end
		bits     = pixel_bits();
		per_word = 32 / bits;
		addr     = row_addr() + addr_t'(x / per_word);
		raw      = 16'(mem[addr] >> ((x % per_word) * bits));   // lowest pixel comes first.
		if (bits == 16) begin
			return raw;
		end
		index = int'(raw) % (1 << bits);
		if (bits == 8) begin
			colour = (index + 16 * int'(cfg_palette_offs)) % 256;
		end else begin
			colour = int'(cfg_palette_offs) * 16 + index;
		end
		return {index != 0, 15'(colour)};
	endfunction

	task automatic watch_bus();
		addr_t exp_addr;
		if (prev_vld && !prev_rdy) begin
			check_val("bus_vld held", 32'(1'b1), 32'(bus_vld));
			check_val("bus_addr held", 32'(prev_addr), 32'(bus_addr));
		end
		if (bus_vld && bus_rdy) begin
			if (flush || stale) begin
				stale = 1'b0;   // this beat belongs to the previous scanline.
			end else begin
				exp_addr = row_addr() + addr_t'(fetches);
				check_val("fetch on active row", 32'(1'b1), 32'(row_hit()));
				check_val("fetch address", 32'(exp_addr), 32'(bus_addr));
				fetches = fetches + 1;
			end
		end else if (flush && bus_vld) begin
			stale = 1'b1;
		end
		if (flush) begin
			fetches = 0;
		end
		prev_vld  = bus_vld;
		prev_rdy  = bus_rdy;
		prev_addr = bus_addr;
	endtask

	task automatic step_cycle();
		logic [15:0] exp_pix;
		@(posedge clk);
		if (!en) begin
			check_val("disabled out_vld", 32'(1'b1), 32'(out_vld));
			check_val("disabled out_alpha", 32'(1'b0), 32'(out_alpha));
		end
		if (out_vld && out_rdy && !flush) begin
			if (en) begin
				exp_pix = expected_pixel(beats);
				check_val("pixel alpha", 32'(exp_pix[15]), 32'(out_alpha));
				if (exp_pix[15]) begin
					check_val("pixel data", 32'(exp_pix[14:0]), 32'(out_pixdata));
				end
			end
			beats = beats + 1;
		end
		watch_bus();
		// the memory answers only a request that has already waited, so its address is settled.
		if (bus_vld && !bus_rdy && stall_cycles == 0 && $urandom % 2 == 0) begin
			bus_rdy  <= 1'b1;
			bus_data <= mem[bus_addr];
		end else begin
			bus_rdy  <= 1'b0;
			bus_data <= data_t'($urandom);
		end
		if (stall_cycles > 0) begin
			stall_cycles = stall_cycles - 1;
		end
		out_rdy <= ($urandom % 4 != 0);
	endtask

	task automatic start_scanline(output int cut_at);
		coord_t sx;
		coord_t sy;
		logic   ts;
		int     mode;
		sx   = coord_t'($urandom % 64);
		sy   = coord_t'($urandom);
		ts   = 1'($urandom);
		mode = int'($urandom % 4);
		if (mode == 3) begin
			mode = 3 + int'($urandom % 5);
		end
		flush            <= 1'b1;
		en               <= ($urandom % 8 != 0);
		cfg_tilesize     <= ts;
		cfg_pixel_mode   <= pixel_mode_t'(mode);
		cfg_palette_offs <= 4'($urandom);
		cfg_sprite_x     <= sx;
		cfg_sprite_y     <= sy;
		beam_y           <= coord_t'(int'(sy) + int'($urandom % 25) - 4);
		cfg_base_addr    <= addr_t'($urandom);
		beats = 0;
		if (prev_vld && !prev_rdy) begin
			bus_rdy      <= 1'b0;   // keep the open beat stalled across the flush.
			stall_cycles = int'($urandom % 4);
		end
		if ($urandom % 4 == 0) begin
			cut_at = int'(sx) + 1 + int'($urandom % (ts ? 16 : 8));
		end else begin
			cut_at = LINE_BEATS;
		end
	endtask

	initial begin
		int i;
		int line;
		int cut_at;
		void'($urandom(SEED));
		for (i = 0; i < 65536; i = i + 1) begin
			mem[i] = $urandom;
		end
		rst_n            = 1'b0;
		flush            = 1'b0;
		en               = 1'b0;
		beam_y           = '0;
		cfg_tilesize     = 1'b0;
		cfg_pixel_mode   = MODE_ARGB1555;
		cfg_palette_offs = 4'h0;
		cfg_sprite_x     = '0;
		cfg_sprite_y     = '0;
		cfg_base_addr    = '0;
		bus_rdy          = 1'b0;
		bus_data         = '0;
		out_rdy          = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) step_cycle();
		for (line = 0; line < N_LINES; line = line + 1) begin
			start_scanline(cut_at);
			step_cycle();
			flush <= 1'b0;
			// a cut scanline ends early while a bus request is still open.
			while (beats < LINE_BEATS && !(beats >= cut_at && prev_vld && !prev_rdy)) begin
				step_cycle();
			end
		end
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/ppu_sprite_pkg.sv
src/sprite_agu.sv
src/pixel_streamer.sv
src/sprite_ctrl.sv
src/ppu_sprite.sv
tb/tb_ppu_sprite.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
PASS_MSG="Simulation finished: PASS"

verilator --binary --timing -j 0 \
	-f files.f \
	--top-module tb_ppu_sprite \
	-Mdir "$BUILD_DIR" \
	-o sim_ppu_sprite
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_ppu_sprite" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
	echo "test passed"
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
